// ==== tb.f ====
+incdir+source
source/fdiv_pkg.sv
source/fdiv_classify.sv
source/fdiv_mant_divider.sv
source/fdiv_normalize_round.sv
source/fdiv_sequencer.sv
source/fdiv_top.sv
bench/fdiv_tb.sv

// ==== Bender.yml ====
package:
  name: fdiv

sources:
  - include_dirs:
      - source
    files:
      - source/fdiv_pkg.sv
      - source/fdiv_classify.sv
      - source/fdiv_mant_divider.sv
      - source/fdiv_normalize_round.sv
      - source/fdiv_sequencer.sv
      - source/fdiv_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/fdiv_tb.sv

// ==== bench/fdiv_tb.sv ====
`timescale 1ns/100ps

`include "fdiv_defs.svh"

module fdiv_tb import fdiv_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        enable;
    ext_float_t  operand_a;
    ext_float_t  operand_b;
    round_mode_t rounding_mode;
    ext_float_t  result;
    logic        done;
    logic        flag_invalid;
    logic        flag_div_by_zero;
    logic        flag_overflow;
    logic        flag_underflow;
    logic        flag_inexact;

    // Expected response of the operation in flight
    ext_float_t  exp_result;
    logic [4:0]  exp_flags;
    string       test_name;

    int          value_errors;
    int          latency_errors;
    int          timeout_errors;
    int          done_errors;
    int          done_count;
    int          ops_issued;
    logic [31:0] lcg_state;

    localparam int FINITE_LATENCY  = 2 + `FDIV_DIV_STEPS + 1;
    localparam int SPECIAL_LATENCY = 2;
    localparam int WAIT_LIMIT      = 200;

    fdiv_top fdiv_top_inst (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .operand_a        (operand_a),
        .operand_b        (operand_b),
        .rounding_mode    (rounding_mode),
        .result           (result),
        .done             (done),
        .flag_invalid     (flag_invalid),
        .flag_div_by_zero (flag_div_by_zero),
        .flag_overflow    (flag_overflow),
        .flag_underflow   (flag_underflow),
        .flag_inexact     (flag_inexact)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // Helpers and reference model
    // ============================================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic ext_float_t pack_float(logic s, logic [14:0] e, logic [63:0] m);
        return {s, e, m};
    endfunction

    // Returns {result, invalid, div_by_zero, overflow, underflow, inexact}
    function automatic logic [84:0] ref_divide(ext_float_t a, ext_float_t b, logic [1:0] mode);
        logic         sign;
        logic [14:0]  ea;
        logic [14:0]  eb;
        logic [63:0]  ma;
        logic [63:0]  mb;
        logic         za;
        logic         zb;
        logic         ia;
        logic         ib;
        logic         na;
        logic         nb;
        logic         pre;
        logic [130:0] num;
        logic [130:0] q_full;
        logic [66:0]  q;
        logic         rem_nz;
        logic [63:0]  kept;
        logic [64:0]  sum;
        logic         g;
        logic         r;
        logic         s;
        logic         lost;
        logic         inc;
        int           e;
        int           lz;
        sign = a[79] ^ b[79];
        ea = a[78:64];
        eb = b[78:64];
        ma = a[63:0];
        mb = b[63:0];
        za = (ea == 15'd0) && (ma == 64'd0);
        zb = (eb == 15'd0) && (mb == 64'd0);
        ia = (ea == 15'h7FFF) && (ma == 64'h8000_0000_0000_0000);
        ib = (eb == 15'h7FFF) && (mb == 64'h8000_0000_0000_0000);
        na = (ea == 15'h7FFF) && !ia;
        nb = (eb == 15'h7FFF) && !ib;
        if (na || nb || (za && zb) || (ia && ib)) begin
            return {1'b0, 15'h7FFF, 64'hC000_0000_0000_0000, 5'b10000};
        end
        if (zb) begin
            return {sign, 15'h7FFF, 64'h8000_0000_0000_0000, 5'b01000};
        end
        if (ia) begin
            return {sign, 15'h7FFF, 64'h8000_0000_0000_0000, 5'b00000};
        end
        if (za || ib) begin
            return {sign, 79'd0, 5'b00000};
        end
        // Quotient with its leading one at bit 66
        pre = ma < mb;
        num = pre ? ({67'd0, ma} << 67) : ({67'd0, ma} << 66);
        q_full = num / {67'd0, mb};
        rem_nz = (num % {67'd0, mb}) != 131'd0;
        q = q_full[66:0];
        lz = 0;
        while ((lz < 67) && !q[66]) begin
            q = q << 1;
            lz++;
        end
        e = int'(ea) - int'(eb) + `FDIV_EXP_BIAS - int'(pre) - lz;
        if (e > `FDIV_EXP_MAX_FINITE) begin
            return {sign, 15'h7FFF, 64'h8000_0000_0000_0000, 5'b00100};
        end
        if (e < 1) begin
            return {sign, 79'd0, 5'b00010};
        end
        kept = q[66:3];
        g = q[2];
        r = q[1];
        s = q[0] | rem_nz;
        lost = g | r | s;
        case (mode)
            `FDIV_RND_NEAREST: inc = g & (r | s | kept[0]);
            `FDIV_RND_DOWN:    inc = sign & lost;
            `FDIV_RND_UP:      inc = ~sign & lost;
            default:           inc = 1'b0;
        endcase
        sum = {1'b0, kept} + {64'd0, inc};
        if (sum[64]) begin
            kept = sum[64:1];
            e = e + 1;
        end else begin
            kept = sum[63:0];
        end
        if (e > `FDIV_EXP_MAX_FINITE) begin
            return {sign, 15'h7FFF, 64'h8000_0000_0000_0000, 4'b0010, lost};
        end
        return {sign, e[14:0], kept, 4'b0000, lost};
    endfunction

    function automatic ext_float_t random_normal(int exp_span);
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] ex;
        hi = lcg_next();
        lo = lcg_next();
        ex = lcg_next();
        return pack_float(hi[31], 15'(`FDIV_EXP_BIAS - exp_span / 2 + int'(ex[15:0]) % exp_span),
                          {1'b1, hi[30:0], lo});
    endfunction

    // ============================================================
    // Result comparison on every done pulse
    // ============================================================

    always @(negedge clk) begin
        if (!reset && done) begin
            done_count++;
            assert ({result, flag_invalid, flag_div_by_zero, flag_overflow,
                     flag_underflow, flag_inexact} === {exp_result, exp_flags})
            else begin
                value_errors++;
                $display("ERROR %s: expected %h flags %b, actual %h flags %b", test_name,
                         exp_result, exp_flags, result, {flag_invalid, flag_div_by_zero,
                         flag_overflow, flag_underflow, flag_inexact});
            end
        end
    end

    // Runs one operation and pulses enable with other operands at poke_cycle when it is set
    task automatic run_op(input string name, input ext_float_t a, input ext_float_t b,
                          input round_mode_t mode, input int latency, input int poke_cycle);
        logic [84:0] expected;
        int          cycles;
        @(negedge clk);
        expected      = ref_divide(a, b, mode);
        exp_result    = expected[84:5];
        exp_flags     = expected[4:0];
        test_name     = name;
        operand_a     = a;
        operand_b     = b;
        rounding_mode = mode;
        enable        = 1'b1;
        ops_issued++;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            enable = 1'b0;
            if (cycles == poke_cycle) begin
                operand_a     = random_normal(64);
                operand_b     = random_normal(64);
                rounding_mode = 2'(lcg_next());
                enable        = 1'b1;
            end
        end while (!done && (cycles < WAIT_LIMIT));
        assert (done) else begin
            timeout_errors++;
            $display("Timeout: %s never raised done within %0d cycles", name, cycles);
        end
        if (done) begin
            assert (cycles == latency) else begin
                latency_errors++;
                $display("ERROR %s latency: expected %0d, actual %0d", name, latency, cycles);
            end
        end
    endtask

    // ============================================================
    // Stimulus
    // ============================================================

    initial begin
        ext_float_t special_vals[8];
        ext_float_t a;
        ext_float_t b;
        ext_float_t two;
        int         total;
        reset          = 1'b1;
        enable         = 1'b0;
        operand_a      = '0;
        operand_b      = '0;
        rounding_mode  = '0;
        exp_result     = '0;
        exp_flags      = '0;
        test_name      = "reset";
        value_errors   = 0;
        latency_errors = 0;
        timeout_errors = 0;
        done_errors    = 0;
        done_count     = 0;
        ops_issued     = 0;
        lcg_state      = 32'd77572;

        repeat (8) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert ({result, done, flag_invalid, flag_div_by_zero, flag_overflow,
                 flag_underflow, flag_inexact} === '0)
        else begin
            value_errors++;
            $display("ERROR reset: expected all zero, actual result %h done %b flags %b",
                     result, done, {flag_invalid, flag_div_by_zero, flag_overflow,
                     flag_underflow, flag_inexact});
        end

        // Every pairing of zeros, infinities, NaNs and two finite values
        special_vals[0] = pack_float(1'b0, 15'd0, 64'd0);
        special_vals[1] = pack_float(1'b1, 15'd0, 64'd0);
        special_vals[2] = pack_float(1'b0, 15'h7FFF, 64'h8000_0000_0000_0000);
        special_vals[3] = pack_float(1'b1, 15'h7FFF, 64'h8000_0000_0000_0000);
        special_vals[4] = pack_float(1'b0, 15'h7FFF, 64'hC000_0000_0000_0000);
        special_vals[5] = pack_float(1'b1, 15'h7FFF, 64'h0000_0000_0000_0001);
        special_vals[6] = pack_float(1'b0, 15'd16383, 64'hC000_0000_0000_0000);
        special_vals[7] = pack_float(1'b1, 15'd16384, 64'hC000_0000_0000_0000);
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                if ((i < 6) || (j < 6)) begin
                    run_op($sformatf("special %0d/%0d", i, j), special_vals[i],
                           special_vals[j], 2'(i), SPECIAL_LATENCY, 0);
                end
            end
        end

        // 6 / 3 and x / x are exact in every mode
        two = pack_float(1'b0, 15'd16384, 64'h8000_0000_0000_0000);
        for (int m = 0; m < 4; m++) begin
            run_op($sformatf("six by three mode %0d", m),
                   pack_float(1'b0, 15'd16385, 64'hC000_0000_0000_0000),
                   pack_float(1'b0, 15'd16384, 64'hC000_0000_0000_0000),
                   2'(m), FINITE_LATENCY, 0);
            assert ((result === two) && !flag_inexact) else begin
                value_errors++;
                $display("ERROR six by three: expected %h exact, actual %h inexact %b",
                         two, result, flag_inexact);
            end
            a = random_normal(8000);
            run_op($sformatf("self ratio mode %0d", m), a, a, 2'(m), FINITE_LATENCY, 0);
            assert (!flag_inexact) else begin
                value_errors++;
                $display("ERROR self ratio: expected inexact 0, actual 1");
            end
        end

        // Random normals in both orders so either divider path runs
        for (int k = 0; k < 24; k++) begin
            a = random_normal(8192);
            b = random_normal(8192);
            for (int m = 0; m < 4; m++) begin
                run_op($sformatf("random %0d a/b mode %0d", k, m), a, b, 2'(m),
                       FINITE_LATENCY, 0);
                run_op($sformatf("random %0d b/a mode %0d", k, m), b, a, 2'(m),
                       FINITE_LATENCY, 0);
            end
        end

        // Exponent range edges
        run_op("overflow", pack_float(1'b0, 15'd32766, 64'hC000_0000_0000_0000),
               pack_float(1'b1, 15'd1, 64'h8000_0000_0000_0000), 2'd0, FINITE_LATENCY, 0);
        run_op("largest finite", pack_float(1'b0, 15'd32766, 64'hC000_0000_0000_0000),
               pack_float(1'b0, 15'd16383, 64'h8000_0000_0000_0000), 2'd0, FINITE_LATENCY, 0);
        run_op("just over", pack_float(1'b1, 15'd32766, 64'hC000_0000_0000_0000),
               pack_float(1'b0, 15'd16382, 64'h8000_0000_0000_0000), 2'd2, FINITE_LATENCY, 0);
        run_op("underflow", pack_float(1'b1, 15'd1, 64'hC000_0000_0000_0000),
               pack_float(1'b0, 15'd32766, 64'h8000_0000_0000_0000), 2'd0, FINITE_LATENCY, 0);
        run_op("smallest normal", pack_float(1'b0, 15'd1, 64'hC000_0000_0000_0000),
               pack_float(1'b0, 15'd16383, 64'h8000_0000_0000_0000), 2'd0, FINITE_LATENCY, 0);
        run_op("pre-shift underflow", pack_float(1'b0, 15'd1, 64'h8000_0000_0000_0000),
               pack_float(1'b1, 15'd16383, 64'hC000_0000_0000_0000), 2'd1, FINITE_LATENCY, 0);
        // Ratio just under two leaves the kept bits close to a rounding carry
        for (int m = 0; m < 4; m++) begin
            run_op($sformatf("max ratio mode %0d", m),
                   pack_float(1'b0, 15'd16383, 64'hFFFF_FFFF_FFFF_FFFF),
                   pack_float(1'b0, 15'd16383, 64'h8000_0000_0000_0001),
                   2'(m), FINITE_LATENCY, 0);
        end

        // Enable while busy must not disturb the running operation
        run_op("enable while busy", random_normal(64), random_normal(64), 2'd0,
               FINITE_LATENCY, 10);
        repeat (FINITE_LATENCY + 10) @(negedge clk);
        assert (done_count == ops_issued) else begin
            done_errors++;
            $display("Done pulse count is %0d but %0d operations were issued",
                     done_count, ops_issued);
        end

        total = value_errors + latency_errors + timeout_errors + done_errors;
        $display("Errors: value %0d, latency %0d, timeout %0d, done count %0d",
                 value_errors, latency_errors, timeout_errors, done_errors);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== source/fdiv_top.sv ====
`timescale 1ns/100ps

module fdiv_top import fdiv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  ext_float_t  operand_a,
    input  ext_float_t  operand_b,
    input  round_mode_t rounding_mode,
    output ext_float_t  result,
    output logic        done,
    output logic        flag_invalid,
    output logic        flag_div_by_zero,
    output logic        flag_overflow,
    output logic        flag_underflow,
    output logic        flag_inexact
);

    ext_float_t  cap_a;
    ext_float_t  cap_b;
    round_mode_t cap_mode;
    logic        special_hit;
    ext_float_t  special_result;
    logic        special_invalid;
    logic        special_div_by_zero;
    logic        div_start;
    logic        div_done;
    quot_t       quotient;
    logic        remainder_nonzero;
    logic        pre_shifted;
    ext_float_t  final_result;
    logic        final_overflow;
    logic        final_underflow;
    logic        final_inexact;

    fdiv_sequencer fdiv_sequencer_inst (
        .clk                 (clk),
        .reset               (reset),
        .enable              (enable),
        .operand_a           (operand_a),
        .operand_b           (operand_b),
        .rounding_mode       (rounding_mode),
        .cap_a               (cap_a),
        .cap_b               (cap_b),
        .cap_mode            (cap_mode),
        .special_hit         (special_hit),
        .special_result      (special_result),
        .special_invalid     (special_invalid),
        .special_div_by_zero (special_div_by_zero),
        .div_start           (div_start),
        .div_done            (div_done),
        .final_result        (final_result),
        .final_overflow      (final_overflow),
        .final_underflow     (final_underflow),
        .final_inexact       (final_inexact),
        .result              (result),
        .done                (done),
        .flag_invalid        (flag_invalid),
        .flag_div_by_zero    (flag_div_by_zero),
        .flag_overflow       (flag_overflow),
        .flag_underflow      (flag_underflow),
        .flag_inexact        (flag_inexact)
    );

    fdiv_classify fdiv_classify_inst (
        .operand_a           (cap_a),
        .operand_b           (cap_b),
        .special_hit         (special_hit),
        .special_result      (special_result),
        .special_invalid     (special_invalid),
        .special_div_by_zero (special_div_by_zero)
    );

    // Significands are the low 64 bits, integer bit included
    fdiv_mant_divider fdiv_mant_divider_inst (
        .clk               (clk),
        .reset             (reset),
        .start             (div_start),
        .dividend          (cap_a[63:0]),
        .divisor           (cap_b[63:0]),
        .quotient          (quotient),
        .remainder_nonzero (remainder_nonzero),
        .pre_shifted       (pre_shifted),
        .div_done          (div_done)
    );

    fdiv_normalize_round fdiv_normalize_round_inst (
        .sign              (cap_a[79] ^ cap_b[79]),
        .exp_a             (cap_a[78:64]),
        .exp_b             (cap_b[78:64]),
        .pre_shifted       (pre_shifted),
        .quotient          (quotient),
        .remainder_nonzero (remainder_nonzero),
        .rounding_mode     (cap_mode),
        .result            (final_result),
        .overflow          (final_overflow),
        .underflow         (final_underflow),
        .inexact           (final_inexact)
    );

endmodule

// ==== source/fdiv_sequencer.sv ====
`timescale 1ns/100ps

module fdiv_sequencer import fdiv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        enable,
    input  ext_float_t  operand_a,
    input  ext_float_t  operand_b,
    input  round_mode_t rounding_mode,
    output ext_float_t  cap_a,
    output ext_float_t  cap_b,
    output round_mode_t cap_mode,
    input  logic        special_hit,
    input  ext_float_t  special_result,
    input  logic        special_invalid,
    input  logic        special_div_by_zero,
    output logic        div_start,
    input  logic        div_done,
    input  ext_float_t  final_result,
    input  logic        final_overflow,
    input  logic        final_underflow,
    input  logic        final_inexact,
    output ext_float_t  result,
    output logic        done,
    output logic        flag_invalid,
    output logic        flag_div_by_zero,
    output logic        flag_overflow,
    output logic        flag_underflow,
    output logic        flag_inexact
);

    fdiv_state_t state;
    logic        accept;

    assign accept    = (state == state_idle) && enable;
    assign div_start = (state == state_classify) && !special_hit;

    // ============================================================
    // Control FSM and output registers
    // ============================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state            <= state_idle;
            result           <= '0;
            done             <= 1'b0;
            flag_invalid     <= 1'b0;
            flag_div_by_zero <= 1'b0;
            flag_overflow    <= 1'b0;
            flag_underflow   <= 1'b0;
            flag_inexact     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                state_idle: begin
                    if (enable) begin
                        flag_invalid     <= 1'b0;
                        flag_div_by_zero <= 1'b0;
                        flag_overflow    <= 1'b0;
                        flag_underflow   <= 1'b0;
                        flag_inexact     <= 1'b0;
                        state            <= state_classify;
                    end
                end
                state_classify: begin
                    if (special_hit) begin
                        result           <= special_result;
                        flag_invalid     <= special_invalid;
                        flag_div_by_zero <= special_div_by_zero;
                        done             <= 1'b1;
                        state            <= state_idle;
                    end else begin
                        state <= state_divide;
                    end
                end
                state_divide: begin
                    if (div_done) begin
                        state <= state_finish;
                    end
                end
                state_finish: begin
                    result         <= final_result;
                    flag_overflow  <= final_overflow;
                    flag_underflow <= final_underflow;
                    flag_inexact   <= final_inexact;
                    done           <= 1'b1;
                    state          <= state_idle;
                end
                default: state <= state_idle;
            endcase
        end
    end

    // Operands stay frozen for the whole operation
    always_ff @(posedge clk) begin
        if (accept) begin
            cap_a    <= operand_a;
            cap_b    <= operand_b;
            cap_mode <= rounding_mode;
        end
    end

endmodule

// ==== source/fdiv_normalize_round.sv ====
`timescale 1ns/100ps

`include "fdiv_defs.svh"

module fdiv_normalize_round import fdiv_pkg::*; (
    input  logic        sign,
    input  exp_t        exp_a,
    input  exp_t        exp_b,
    input  logic        pre_shifted,
    input  quot_t       quotient,
    input  logic        remainder_nonzero,
    input  round_mode_t rounding_mode,
    output ext_float_t  result,
    output logic        overflow,
    output logic        underflow,
    output logic        inexact
);

    wide_exp_t  exp_base;
    wide_exp_t  exp_norm;
    wide_exp_t  exp_final;
    logic [6:0] lead_shift;
    logic       lead_found;
    quot_t      norm_quot;
    mant_t      kept_mant;
    mant_t      mant_final;
    logic [64:0] rounded;
    logic       guard;
    logic       round_bit;
    logic       sticky;
    logic       lost_bits;
    logic       round_up;
    logic       carry;

    // ============================================================
    // Exponent and normalization
    // ============================================================

    assign exp_base = wide_exp_t'({2'b00, exp_a}) - wide_exp_t'({2'b00, exp_b})
                    + wide_exp_t'(`FDIV_EXP_BIAS) - wide_exp_t'({16'd0, pre_shifted});

    // Leading zero count, only nonzero for denormal inputs
    always_comb begin
        lead_shift = 7'd0;
        lead_found = 1'b0;
        for (int i = `FDIV_QUOT_BITS - 1; i >= 0; i--) begin
            if (!lead_found) begin
                if (quotient[i]) begin
                    lead_found = 1'b1;
                end else begin
                    lead_shift = lead_shift + 7'd1;
                end
            end
        end
    end

    assign norm_quot = quotient << lead_shift;
    assign exp_norm  = exp_base - wide_exp_t'({10'd0, lead_shift});

    // ============================================================
    // Rounding
    // ============================================================

    assign kept_mant = norm_quot[66:3];
    assign guard     = norm_quot[2];
    assign round_bit = norm_quot[1];
    assign sticky    = norm_quot[0] | remainder_nonzero;
    assign lost_bits = guard | round_bit | sticky;

    always_comb begin
        round_up = 1'b0;
        case (rounding_mode)
            `FDIV_RND_NEAREST: round_up = guard & (round_bit | sticky | kept_mant[0]);
            `FDIV_RND_DOWN:    round_up = sign & lost_bits;
            `FDIV_RND_UP:      round_up = ~sign & lost_bits;
            `FDIV_RND_ZERO:    round_up = 1'b0;
        endcase
    end

    assign rounded    = {1'b0, kept_mant} + {64'd0, round_up};
    assign carry      = rounded[64];
    assign mant_final = carry ? rounded[64:1] : rounded[63:0];
    assign exp_final  = exp_norm + wide_exp_t'({16'd0, carry});

    // Range check before rounding, then again after a carry-out
    always_comb begin
        overflow  = 1'b0;
        underflow = 1'b0;
        inexact   = 1'b0;
        if (exp_norm > wide_exp_t'(`FDIV_EXP_MAX_FINITE)) begin
            result   = {sign, `FDIV_EXP_ALL_ONES, 1'b1, 63'd0};
            overflow = 1'b1;
        end else if (exp_norm < wide_exp_t'(1)) begin
            // No denormal results, flush to signed zero
            result    = {sign, 79'd0};
            underflow = 1'b1;
        end else begin
            inexact = lost_bits;
            if (exp_final > wide_exp_t'(`FDIV_EXP_MAX_FINITE)) begin
                result   = {sign, `FDIV_EXP_ALL_ONES, 1'b1, 63'd0};
                overflow = 1'b1;
            end else begin
                result = {sign, exp_t'(exp_final[14:0]), mant_final};
            end
        end
    end

endmodule

// ==== source/fdiv_mant_divider.sv ====
`timescale 1ns/100ps

`include "fdiv_defs.svh"

module fdiv_mant_divider import fdiv_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  mant_t dividend,
    input  mant_t divisor,
    output quot_t quotient,
    output logic  remainder_nonzero,
    output logic  pre_shifted,
    output logic  div_done
);

    logic [128:0] rem_q;
    logic [128:0] rem_init;
    logic [128:0] rem_cur;
    logic [128:0] rem_next;
    logic [64:0]  rem_upper;
    quot_t        quot_cur;
    logic         pre_shift_now;
    logic         take;
    logic         busy;
    logic         stepping;
    logic         last_step;
    logic [6:0]   step_count;

    // ============================================================
    // Iteration datapath
    // ============================================================

    // A smaller dividend sits one place higher so bit 66 leads
    assign pre_shift_now = dividend < divisor;
    assign rem_init = pre_shift_now ? {dividend, 65'd0} : {1'b0, dividend, 64'd0};

    // The start cycle already runs the first step on the fresh remainder
    assign stepping = start | busy;
    assign rem_cur  = start ? rem_init : rem_q;
    assign quot_cur = start ? '0 : quotient;

    assign rem_upper = rem_cur[128:64];
    assign take      = rem_upper >= {1'b0, divisor};
    assign rem_next  = take ? {rem_upper - {1'b0, divisor}, rem_cur[63:0]} : rem_cur;

    assign last_step = busy && (step_count == 7'(`FDIV_DIV_STEPS - 1));

    // ============================================================
    // Step control
    // ============================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            step_count <= 7'd0;
            div_done   <= 1'b0;
        end else begin
            div_done <= last_step;
            if (start) begin
                busy       <= 1'b1;
                step_count <= 7'd1;
            end else if (last_step) begin
                busy       <= 1'b0;
                step_count <= 7'd0;
            end else if (busy) begin
                step_count <= step_count + 7'd1;
            end
        end
    end

    // Quotient fills MSB first; everything holds once stepping stops
    always_ff @(posedge clk) begin
        if (stepping) begin
            rem_q             <= rem_next << 1;
            quotient          <= {quot_cur[`FDIV_QUOT_BITS-2:0], take};
            remainder_nonzero <= |rem_next;
        end
        if (start) begin
            pre_shifted <= pre_shift_now;
        end
    end

endmodule

// ==== source/fdiv_classify.sv ====
`timescale 1ns/100ps

`include "fdiv_defs.svh"

module fdiv_classify import fdiv_pkg::*; (
    input  ext_float_t operand_a,
    input  ext_float_t operand_b,
    output logic       special_hit,
    output ext_float_t special_result,
    output logic       special_invalid,
    output logic       special_div_by_zero
);

    logic sign_res;
    logic zero_a;
    logic zero_b;
    logic inf_a;
    logic inf_b;
    logic nan_a;
    logic nan_b;

    function automatic logic is_zero(ext_float_t x);
        return (exp_t'(x[78:64]) == '0) && (mant_t'(x[63:0]) == '0);
    endfunction

    // Infinity needs the integer bit set and an empty fraction
    function automatic logic is_inf(ext_float_t x);
        return (x[78:64] == `FDIV_EXP_ALL_ONES) && (x[63:0] == {1'b1, 63'd0});
    endfunction

    function automatic logic is_nan(ext_float_t x);
        return (x[78:64] == `FDIV_EXP_ALL_ONES) && (x[63:0] != {1'b1, 63'd0});
    endfunction

    assign zero_a   = is_zero(operand_a);
    assign zero_b   = is_zero(operand_b);
    assign inf_a    = is_inf(operand_a);
    assign inf_b    = is_inf(operand_b);
    assign nan_a    = is_nan(operand_a);
    assign nan_b    = is_nan(operand_b);
    assign sign_res = operand_a[79] ^ operand_b[79];

    // Anything not finite and nonzero on either side ends here
    assign special_hit = zero_a | zero_b | inf_a | inf_b | nan_a | nan_b;

    always_comb begin
        special_invalid     = 1'b0;
        special_div_by_zero = 1'b0;
        if (nan_a || nan_b || (zero_a && zero_b) || (inf_a && inf_b)) begin
            special_result  = {1'b0, `FDIV_EXP_ALL_ONES, 2'b11, 62'd0};
            special_invalid = 1'b1;
        end else if (zero_b) begin
            special_result      = {sign_res, `FDIV_EXP_ALL_ONES, 1'b1, 63'd0};
            special_div_by_zero = 1'b1;
        end else if (inf_a) begin
            special_result = {sign_res, `FDIV_EXP_ALL_ONES, 1'b1, 63'd0};
        end else begin
            // Zero dividend or infinite divisor
            special_result = {sign_res, 79'd0};
        end
    end

endmodule

// ==== source/fdiv_pkg.sv ====
`include "fdiv_defs.svh"

package fdiv_pkg;

    // ============================================================
    // Data types
    // ============================================================

    // Packed operand or result: sign, exponent, integer bit, fraction
    typedef logic [79:0] ext_float_t;

    // Biased exponent field
    typedef logic [14:0] exp_t;

    // Significand including the explicit integer bit
    typedef logic [63:0] mant_t;

    // Raw quotient with guard, round and sticky positions
    typedef logic [`FDIV_QUOT_BITS-1:0] quot_t;

    // Working exponent, wide enough for overflow and underflow
    typedef logic signed [16:0] wide_exp_t;

    typedef logic [1:0] round_mode_t;

    // ============================================================
    // Sequencer states
    // ============================================================

    typedef enum logic [1:0] {
        state_idle,
        state_classify,
        state_divide,
        state_finish
    } fdiv_state_t;

endpackage

// ==== source/fdiv_defs.svh ====
`ifndef FDIV_DEFS_SVH
`define FDIV_DEFS_SVH

// ============================================================
// 80-bit extended format constants
// ============================================================

// Exponent bias of the extended format
`define FDIV_EXP_BIAS 16383

// Reserved exponent for infinity and NaN
`define FDIV_EXP_ALL_ONES 15'h7FFF

// Largest exponent of a normal result
`define FDIV_EXP_MAX_FINITE 32766

// ============================================================
// Divider sizing
// ============================================================

// 64 kept bits plus guard, round and sticky
`define FDIV_QUOT_BITS 67

// One quotient bit per iteration
`define FDIV_DIV_STEPS 67

// Rounding mode codes
`define FDIV_RND_NEAREST 2'd0
`define FDIV_RND_DOWN 2'd1
`define FDIV_RND_UP 2'd2
`define FDIV_RND_ZERO 2'd3

`endif
